/* hw/qspi_pkg.sv */
// shared constants and types of the quad-SPI controller
// address bits 25:24 pick the chip enable, value 3 selects no chip
// outputs leave out_dly clocks after a stage change
package qspi_pkg;

	localparam int adr_w       = 26;
	localparam int flash_adr_w = 24;
	localparam int num_ce      = 3;
	localparam int sck_div_w   = 10;
	localparam int lat_w       = 4;
	localparam int cmd_w       = 8;
	localparam int sync_depth  = 2;
	localparam int apb_adr_w   = 8;

	// output pipeline depth and the resulting sample delay behind the pin clock
	localparam int out_dly    = 2;
	localparam int sample_dly = out_dly + sync_depth;

	localparam logic [sck_div_w-1:0] sck_div_rst = 10'd1;
	localparam logic [lat_w-1:0]     lat_rst     = 4'd7;
	localparam logic [cmd_w-1:0]     rdcmd_rst   = 8'hEB;
	localparam logic [cmd_w-1:0]     wrcmd_rst   = 8'h38;

	// APB byte offsets
	localparam logic [apb_adr_w-1:0] reg_lat0   = 8'h00;
	localparam logic [apb_adr_w-1:0] reg_lat1   = 8'h04;
	localparam logic [apb_adr_w-1:0] reg_lat2   = 8'h08;
	localparam logic [apb_adr_w-1:0] reg_sckdiv = 8'h0C;
	localparam logic [apb_adr_w-1:0] reg_rdcmd  = 8'h10;
	localparam logic [apb_adr_w-1:0] reg_wrcmd  = 8'h14;

	typedef enum logic [1:0] {
		sz_byte = 2'd0,
		sz_half = 2'd1,
		sz_word = 2'd2
	} xfer_size_t;

	typedef struct packed {
		logic             wr;
		xfer_size_t       size;
		logic [adr_w-1:0] adr;
		logic [31:0]      wdata;
	} mem_req_t;

	typedef struct packed {
		logic [lat_w-1:0]     lat0;
		logic [lat_w-1:0]     lat1;
		logic [lat_w-1:0]     lat2;
		logic [sck_div_w-1:0] sck_div;
		logic [cmd_w-1:0]     rdcmd;
		logic [cmd_w-1:0]     wrcmd;
	} qspi_cfg_t;

	typedef enum logic [3:0] {
		st_idle   = 4'd0,
		st_cmd    = 4'd1,
		st_adr    = 4'd2,
		st_rdwait = 4'd3,
		st_rddata = 4'd4,
		st_wrdata = 4'd5,
		st_turn   = 4'd6
	} qspi_state_t;

	typedef struct packed {
		logic              sck;
		logic [num_ce-1:0] ce_n;
		logic [3:0]        sio_o;
		logic              sio_en;
	} qspi_pins_t;

endpackage

/* hw/qspi_cfg_regs.sv */
// APB slave for the controller configuration
// no wait states, prdata is a pure decode of paddr during the access phase
// unmapped offsets answer with pslverr and read as zero
// writes during a transfer take effect immediately
`timescale 1ns/1ps

module qspi_cfg_regs
	import qspi_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [apb_adr_w-1:0] paddr,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	output logic                 pslverr,
	output qspi_cfg_t            cfg
);

	logic hit;
	logic wr_en;

	// read mux, unused upper bits stay zero
	always_comb begin
		hit = 1'b1;
		prdata = '0;
		case (paddr)
			reg_lat0:   prdata[lat_w-1:0] = cfg.lat0;
			reg_lat1:   prdata[lat_w-1:0] = cfg.lat1;
			reg_lat2:   prdata[lat_w-1:0] = cfg.lat2;
			reg_sckdiv: prdata[sck_div_w-1:0] = cfg.sck_div;
			reg_rdcmd:  prdata[cmd_w-1:0] = cfg.rdcmd;
			reg_wrcmd:  prdata[cmd_w-1:0] = cfg.wrcmd;
			default:    hit = 1'b0;
		endcase
	end

	assign pready = 1'b1;
	assign pslverr = psel & penable & ~hit;
	assign wr_en = psel & penable & pwrite & hit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg.lat0 <= lat_rst;
			cfg.lat1 <= lat_rst;
			cfg.lat2 <= lat_rst;
			cfg.sck_div <= sck_div_rst;
			cfg.rdcmd <= rdcmd_rst;
			cfg.wrcmd <= wrcmd_rst;
		end else if (wr_en) begin
			case (paddr)
				reg_lat0:   cfg.lat0 <= pwdata[lat_w-1:0];
				reg_lat1:   cfg.lat1 <= pwdata[lat_w-1:0];
				reg_lat2:   cfg.lat2 <= pwdata[lat_w-1:0];
				reg_sckdiv: cfg.sck_div <= pwdata[sck_div_w-1:0];
				reg_rdcmd:  cfg.rdcmd <= pwdata[cmd_w-1:0];
				reg_wrcmd:  cfg.wrcmd <= pwdata[cmd_w-1:0];
				default:    ;
			endcase
		end
	end

endmodule

/* hw/qspi_sck_gen.sv */
// SCK divider, period is 2*(sck_div+1) system clocks
// free running from reset, the pin clock lags the internal one by out_dly
// sample strobe sits sync_depth clocks behind the pin rising edge
`timescale 1ns/1ps

module qspi_sck_gen
	import qspi_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [sck_div_w-1:0] sck_div,
	output logic                 sck_pin,
	output logic                 shift_stb,
	output logic                 sample_stb
);

	logic [sck_div_w-1:0] div_cnt;
	logic                 wrap;
	logic                 sck_pre;
	logic [sample_dly:1]  sck_dly;

	// >= so a smaller divider written mid-count wraps at once
	assign wrap = (div_cnt >= sck_div);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			sck_pre <= 1'b1;
			sck_dly <= '1;
		end else begin
			div_cnt <= wrap ? '0 : div_cnt + 1'b1;
			if (wrap) begin
				sck_pre <= ~sck_pre;
			end
			sck_dly <= {sck_dly[sample_dly-1:1], sck_pre};
		end
	end

	assign sck_pin = sck_dly[out_dly];
	// high in the clock where the internal clock is about to fall
	assign shift_stb = wrap & sck_pre;
	assign sample_stb = sck_dly[sample_dly-1] & ~sck_dly[sample_dly];

endmodule

/* hw/qspi_seq.sv */
// request latch and transfer FSM, one request at a time
// phases are 8 command bits, 6 address nibbles, wait, data, one turnaround
// read nibbles are counted at sample strobes, so sck_div must be 1 or more
// ce_n is delayed out_dly clocks to line up with the data pins
`timescale 1ns/1ps

module qspi_seq
	import qspi_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req,
	input  mem_req_t               req_info,
	input  qspi_cfg_t              cfg,
	input  logic                   shift_stb,
	input  logic                   sample_stb,
	output logic                   busy,
	output logic                   done,
	output qspi_state_t            state,
	output logic [2:0]             nib_idx,
	output logic [num_ce-1:0]      ce_n,
	output logic                   capture,
	output logic [cmd_w-1:0]       cmd,
	output logic [flash_adr_w-1:0] flash_adr,
	output xfer_size_t             size,
	output logic [31:0]            wdata
);

	mem_req_t                       req_q;
	logic                           accept;
	logic [lat_w-1:0]               cnt;
	logic [lat_w-1:0]               lat;
	logic [2:0]                     last_nib;
	logic [adr_w-flash_adr_w-1:0]   chip;
	logic                           cmd_end;
	logic                           adr_end;
	logic                           wait_end;
	logic                           data_end;
	logic [2:0]                     rd_cnt;
	logic [sample_dly-1:0]          rd_dly;
	logic [num_ce-1:0]              ce_pre;
	logic [out_dly-1:0][num_ce-1:0] ce_dly;

	assign accept = req & ~busy;

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req_info;
		end
	end

	assign chip = req_q.adr[adr_w-1:flash_adr_w];

	always_comb begin
		case (chip)
			2'd1:    lat = cfg.lat1;
			2'd2:    lat = cfg.lat2;
			default: lat = cfg.lat0;
		endcase
		case (req_q.size)
			sz_byte: last_nib = 3'd1;
			sz_half: last_nib = 3'd3;
			default: last_nib = 3'd7;
		endcase
	end

	assign cmd_end = (cnt == lat_w'(7));
	assign adr_end = (cnt == lat_w'(5));
	assign wait_end = (cnt == lat - 1'b1);
	assign data_end = (cnt == {1'b0, last_nib});

	// state and phase counter move on the falling SCK edge only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			cnt <= '0;
		end else if (shift_stb) begin
			cnt <= cnt + 1'b1;
			case (state)
				st_idle: begin
					cnt <= '0;
					if (busy) begin
						state <= st_cmd;
					end
				end
				st_cmd: begin
					if (cmd_end) begin
						state <= st_adr;
						cnt <= '0;
					end
				end
				st_adr: begin
					if (adr_end) begin
						cnt <= '0;
						if (req_q.wr) begin
							state <= st_wrdata;
						end else if (lat == '0) begin
							state <= st_rddata;
						end else begin
							state <= st_rdwait;
						end
					end
				end
				st_rdwait: begin
					if (wait_end) begin
						state <= st_rddata;
						cnt <= '0;
					end
				end
				st_rddata, st_wrdata: begin
					if (data_end) begin
						state <= st_turn;
						cnt <= '0;
					end
				end
				default: begin
					state <= st_idle;
					cnt <= '0;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			rd_cnt <= '0;
			rd_dly <= '0;
			ce_dly <= '1;
		end else begin
			if (accept) begin
				busy <= 1'b1;
			end else if (shift_stb && state == st_turn) begin
				busy <= 1'b0;
			end
			done <= (capture && rd_cnt == last_nib) ||
				(shift_stb && state == st_wrdata && data_end);
			if (state == st_idle) begin
				rd_cnt <= '0;
			end else if (capture) begin
				rd_cnt <= rd_cnt + 1'b1;
			end
			// read phase flag follows the pin clock through pins and synchronizer
			rd_dly <= {rd_dly[sample_dly-2:0], state == st_rddata};
			ce_dly <= {ce_dly[out_dly-2:0], ce_pre};
		end
	end

	assign capture = rd_dly[sample_dly-1] & sample_stb;

	// one-hot chip enable from the top address bits
	always_comb begin
		ce_pre = '1;
		if (state != st_idle && state != st_turn) begin
			for (int i = 0; i < num_ce; i++) begin
				if (chip == i) begin
					ce_pre[i] = 1'b0;
				end
			end
		end
	end

	assign ce_n = ce_dly[out_dly-1];
	assign nib_idx = cnt[2:0];
	assign cmd = req_q.wr ? cfg.wrcmd : cfg.rdcmd;
	assign flash_adr = req_q.adr[flash_adr_w-1:0];
	assign size = req_q.size;
	assign wdata = req_q.wdata;

endmodule

/* hw/qspi_datapath.sv */
// pin data path of the quad-SPI controller
// write bytes go out lowest byte first, high nibble first within a byte
// the first byte received ends up in rdata[7:0], upper bytes zero by size
// rdata is only meaningful in the cycle that done is high
`timescale 1ns/1ps

module qspi_datapath
	import qspi_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  qspi_state_t            state,
	input  logic [2:0]             nib_idx,
	input  logic [cmd_w-1:0]       cmd,
	input  logic [flash_adr_w-1:0] flash_adr,
	input  xfer_size_t             size,
	input  logic [31:0]            wdata,
	input  logic                   capture,
	input  logic [3:0]             sio_i,
	output logic [3:0]             sio_o,
	output logic                   sio_en,
	output logic [31:0]            rdata
);

	logic [3:0]                 nib;
	logic                       nib_en;
	logic [out_dly-1:0][3:0]    sio_dly;
	logic [out_dly-1:0]         en_dly;
	logic [sync_depth-1:0][3:0] sync_ff;
	logic [31:0]                rx;

	always_comb begin
		nib = 4'h0;
		nib_en = 1'b0;
		case (state)
			st_cmd: begin
				// single bit on sio[0], MSB first
				nib = {3'b000, cmd[3'd7 - nib_idx]};
				nib_en = 1'b1;
			end
			st_adr: begin
				nib = flash_adr[{3'd5 - nib_idx, 2'b00} +: 4];
				nib_en = 1'b1;
			end
			st_wrdata: begin
				nib = wdata[{nib_idx[2:1], ~nib_idx[0], 2'b00} +: 4];
				nib_en = 1'b1;
			end
			default: begin
				nib = 4'h0;
				nib_en = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sio_dly <= '0;
			en_dly <= '0;
			sync_ff <= '0;
		end else begin
			sio_dly <= {sio_dly[out_dly-2:0], nib};
			en_dly <= {en_dly[out_dly-2:0], nib_en};
			sync_ff <= {sync_ff[sync_depth-2:0], sio_i};
		end
	end

	assign sio_o = sio_dly[out_dly-1];
	assign sio_en = en_dly[out_dly-1];

	always_ff @(posedge clk) begin
		if (capture) begin
			rx <= {rx[27:0], sync_ff[sync_depth-1]};
		end
	end

	// earliest byte sits highest in rx, swap it down to byte 0
	always_comb begin
		case (size)
			sz_byte: rdata = {24'd0, rx[7:0]};
			sz_half: rdata = {16'd0, rx[7:0], rx[15:8]};
			default: rdata = {rx[7:0], rx[15:8], rx[23:16], rx[31:24]};
		endcase
	end

endmodule

/* hw/qspi_ctrl.sv */
// quad-SPI flash and PSRAM controller top
// APB for configuration, a single-request memory port, three chip enables
// sck is held high whenever no chip enable is active
`timescale 1ns/1ps

module qspi_ctrl
	import qspi_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [apb_adr_w-1:0] paddr,
	input  logic [31:0]          pwdata,
	output logic [31:0]          prdata,
	output logic                 pready,
	output logic                 pslverr,
	input  logic                 req,
	input  mem_req_t             req_info,
	output logic                 busy,
	output logic                 done,
	output logic [31:0]          rdata,
	output qspi_pins_t           pins,
	input  logic [3:0]           sio_i
);

	qspi_cfg_t              cfg;
	logic                   sck_pin;
	logic                   shift_stb;
	logic                   sample_stb;
	qspi_state_t            state;
	logic [2:0]             nib_idx;
	logic [num_ce-1:0]      ce_n;
	logic                   capture;
	logic [cmd_w-1:0]       cmd;
	logic [flash_adr_w-1:0] flash_adr;
	xfer_size_t             size;
	logic [31:0]            wdata;
	logic [3:0]             sio_o;
	logic                   sio_en;

	qspi_cfg_regs u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.cfg     (cfg)
	);

	qspi_sck_gen u_sck (
		.clk        (clk),
		.rst_n      (rst_n),
		.sck_div    (cfg.sck_div),
		.sck_pin    (sck_pin),
		.shift_stb  (shift_stb),
		.sample_stb (sample_stb)
	);

	qspi_seq u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.req_info   (req_info),
		.cfg        (cfg),
		.shift_stb  (shift_stb),
		.sample_stb (sample_stb),
		.busy       (busy),
		.done       (done),
		.state      (state),
		.nib_idx    (nib_idx),
		.ce_n       (ce_n),
		.capture    (capture),
		.cmd        (cmd),
		.flash_adr  (flash_adr),
		.size       (size),
		.wdata      (wdata)
	);

	qspi_datapath u_dp (
		.clk       (clk),
		.rst_n     (rst_n),
		.state     (state),
		.nib_idx   (nib_idx),
		.cmd       (cmd),
		.flash_adr (flash_adr),
		.size      (size),
		.wdata     (wdata),
		.capture   (capture),
		.sio_i     (sio_i),
		.sio_o     (sio_o),
		.sio_en    (sio_en),
		.rdata     (rdata)
	);

	// ce_n and sck_pin share the same delay, so the gating is glitch free
	assign pins.sck = sck_pin | (&ce_n);
	assign pins.ce_n = ce_n;
	assign pins.sio_o = sio_o;
	assign pins.sio_en = sio_en;

endmodule

/* tests/qspi_chk.sv */
// assertions bound to the controller top
// pin rules for chip enable and output enable, and the done pulse width
`timescale 1ns/1ps

module qspi_chk
	import qspi_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input logic       busy,
	input logic       done,
	input qspi_pins_t pins
);

	// driving the data lines needs exactly one selected chip
	one_chip: assert property (@(posedge clk) disable iff (!rst_n)
		pins.sio_en |-> $onehot(~pins.ce_n))
		else $error("sio_en high while ce_n is %b", pins.ce_n);

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done stayed high for two cycles");

	// no pin driving outside a transfer
	idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> !pins.sio_en)
		else $error("sio_en high while busy is low");

endmodule

bind qspi_ctrl qspi_chk chk0 (
	.clk   (clk),
	.rst_n (rst_n),
	.busy  (busy),
	.done  (done),
	.pins  (pins)
);

/* tests/qspi_tb.sv */
// testbench for the quad-SPI controller top
// one behavioural memory per chip enable, 4K bytes each, higher address bits alias
// the memory model needs sck_div of 1 or more and commands that differ
`timescale 1ns/1ps

module qspi_tb
	import qspi_pkg::*;
();

	typedef enum logic [2:0] {
		op_apb_wr,
		op_apb_rd,
		op_mem_wr,
		op_mem_rd,
		op_mem_chk,
		op_busy
	} op_t;

	typedef struct packed {
		op_t         op;
		logic        err;
		xfer_size_t  size;
		logic [25:0] adr;
		logic [31:0] data;
		logic [31:0] exp;
	} test_t;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        req;
	mem_req_t    req_info;
	logic        busy;
	logic        done;
	logic [31:0] rdata;
	qspi_pins_t  pins;
	logic [3:0]  sio_i;

	// table and run bookkeeping
	test_t       tbl [0:47];
	string       tname [0:47];
	int          n_tests = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	logic        test_ok;
	int          cycles = 0;
	int          cycle_limit;
	int          cycle_budget = 0;
	int          build_div = 1;
	logic [31:0] rng;

	// what the testbench has configured, seen by the memory model
	logic [3:0]  mdl_lat [0:2];
	logic [9:0]  shd_div;
	logic [7:0]  shd_rdcmd;
	logic [7:0]  shd_wrcmd;

	// memory model state
	logic [7:0]  flash_mem [0:16383];
	int          rise_n;
	int          xfer_cnt;
	logic        prev_sck;
	logic        in_xfer;
	logic        is_wr;
	logic        is_rd;
	logic [7:0]  cmd_sr;
	logic [7:0]  last_cmd;
	logic [23:0] adr_sr;
	logic [3:0]  hi_nib;

	qspi_ctrl dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.req      (req),
		.req_info (req_info),
		.busy     (busy),
		.done     (done),
		.rdata    (rdata),
		.pins     (pins),
		.sio_i    (sio_i)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not end within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// 39 SCK cycles covers command, address, latency 15, a word and turnaround
	function automatic int xfer_cycles(input int div);
		return 2 * (div + 1) * 39 + 24;
	endfunction

	function automatic int mem_key(input logic [1:0] chip, input logic [23:0] a);
		return {chip, a[11:0]};
	endfunction

	function automatic logic [7:0] fill_byte(input logic [13:0] i);
		return i[7:0] ^ i[13:6] ^ 8'h5a;
	endfunction

	task automatic add_test(input string name, input op_t op, input xfer_size_t sz,
		input logic [25:0] a, input logic [31:0] d, input logic [31:0] e, input logic err);
		test_t t;
		t.op = op;
		t.err = err;
		t.size = sz;
		t.adr = a;
		t.data = d;
		t.exp = e;
		tbl[n_tests] = t;
		tname[n_tests] = name;
		n_tests++;
		if (op == op_apb_wr && a[7:0] == 8'h0C) begin
			build_div = d[9:0];
		end
		if (op == op_apb_wr || op == op_apb_rd) begin
			cycle_budget += 6;
		end else if (op == op_mem_chk) begin
			cycle_budget += 1;
		end else begin
			cycle_budget += xfer_cycles(build_div) + 16;
		end
	endtask

	task automatic report_mismatch(input string name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		$display("** Error %s: %s expected %h, actual %h", name, what, exp, act);
		test_ok = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
		@(posedge clk);
		psel <= 1'b1;
		pwrite <= 1'b1;
		paddr <= a;
		pwdata <= d;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err,
		output logic rdy);
		@(posedge clk);
		psel <= 1'b1;
		pwrite <= 1'b0;
		paddr <= a;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		d = prdata;
		err = pslverr;
		rdy = pready;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// hold keeps req high for that many edges, later ones fall while busy
	task automatic mem_xfer(input logic wr, input xfer_size_t sz, input logic [25:0] a,
		input logic [31:0] d, input int hold, output logic [31:0] got,
		output int dones, output logic late);
		int n;
		int limit;
		n = 0;
		dones = 0;
		got = '0;
		limit = xfer_cycles(shd_div);
		@(posedge clk);
		req <= 1'b1;
		req_info <= {wr, sz, a, d};
		repeat (hold) begin
			@(posedge clk);
			// a different request offered while busy must not disturb the transfer
			req_info <= {~wr, sz, a ^ 26'h1000010, ~d};
			if (done) begin
				dones++;
			end
		end
		req <= 1'b0;
		do begin
			@(posedge clk);
			n++;
			if (done) begin
				dones++;
				got = rdata;
			end
		end while (busy && n < limit);
		late = (n >= limit);
		// a few more edges to catch a stray second done
		repeat (4) begin
			@(posedge clk);
			if (done) begin
				dones++;
			end
		end
	endtask

	task automatic build_table();
		logic [31:0] w [0:6];
		for (int i = 0; i < 7; i++) begin
			rng = xorshift32(rng);
			w[i] = rng;
		end
		add_test("lat0_reset", op_apb_rd, sz_word, 26'h00, 32'h0, 32'h7, 1'b0);
		add_test("lat1_reset", op_apb_rd, sz_word, 26'h04, 32'h0, 32'h7, 1'b0);
		add_test("lat2_reset", op_apb_rd, sz_word, 26'h08, 32'h0, 32'h7, 1'b0);
		add_test("sckdiv_reset", op_apb_rd, sz_word, 26'h0C, 32'h0, 32'h1, 1'b0);
		add_test("rdcmd_reset", op_apb_rd, sz_word, 26'h10, 32'h0, 32'hEB, 1'b0);
		add_test("wrcmd_reset", op_apb_rd, sz_word, 26'h14, 32'h0, 32'h38, 1'b0);
		add_test("rdcmd_write", op_apb_wr, sz_word, 26'h10, 32'h0B, 32'h0, 1'b0);
		add_test("wrcmd_write", op_apb_wr, sz_word, 26'h14, 32'h02, 32'h0, 1'b0);
		add_test("lat0_write", op_apb_wr, sz_word, 26'h00, 32'hFFFF_FFF5, 32'h0, 1'b0);
		add_test("rdcmd_readback", op_apb_rd, sz_word, 26'h10, 32'h0, 32'h0B, 1'b0);
		add_test("wrcmd_readback", op_apb_rd, sz_word, 26'h14, 32'h0, 32'h02, 1'b0);
		add_test("lat0_readback", op_apb_rd, sz_word, 26'h00, 32'h0, 32'h5, 1'b0);
		add_test("unmapped_18", op_apb_rd, sz_word, 26'h18, 32'h0, 32'h0, 1'b1);
		add_test("unmapped_fc", op_apb_rd, sz_word, 26'hFC, 32'h0, 32'h0, 1'b1);
		// write then read on chip 0
		add_test("word_write", op_mem_wr, sz_word, 26'h0000120, w[0], 32'h0, 1'b0);
		add_test("word_bytes", op_mem_chk, sz_word, 26'h0000120, w[0], 32'h0, 1'b0);
		add_test("word_read", op_mem_rd, sz_word, 26'h0000120, 32'h0, w[0], 1'b0);
		add_test("byte_read", op_mem_rd, sz_byte, 26'h0000120, 32'h0, {24'd0, w[0][7:0]}, 1'b0);
		add_test("half_read", op_mem_rd, sz_half, 26'h0000120, 32'h0, {16'd0, w[0][15:0]}, 1'b0);
		add_test("byte_write", op_mem_wr, sz_byte, 26'h0000203, w[1], 32'h0, 1'b0);
		add_test("byte_readback", op_mem_rd, sz_byte, 26'h0000203, 32'h0, {24'd0, w[1][7:0]}, 1'b0);
		add_test("half_write", op_mem_wr, sz_half, 26'h0000302, w[2], 32'h0, 1'b0);
		add_test("half_readback", op_mem_rd, sz_half, 26'h0000302, 32'h0, {16'd0, w[2][15:0]}, 1'b0);
		// same offset on each chip
		add_test("ce0_write", op_mem_wr, sz_word, 26'h0000400, w[3], 32'h0, 1'b0);
		add_test("ce1_write", op_mem_wr, sz_word, 26'h1000400, w[4], 32'h0, 1'b0);
		add_test("ce2_write", op_mem_wr, sz_word, 26'h2000400, w[5], 32'h0, 1'b0);
		add_test("ce0_read", op_mem_rd, sz_word, 26'h0000400, 32'h0, w[3], 1'b0);
		add_test("ce1_read", op_mem_rd, sz_word, 26'h1000400, 32'h0, w[4], 1'b0);
		add_test("ce2_read", op_mem_rd, sz_word, 26'h2000400, 32'h0, w[5], 1'b0);
		// latency and divider changes
		add_test("lat2_set", op_apb_wr, sz_word, 26'h08, 32'h3, 32'h0, 1'b0);
		add_test("sckdiv_set3", op_apb_wr, sz_word, 26'h0C, 32'h3, 32'h0, 1'b0);
		add_test("lat2_readback", op_apb_rd, sz_word, 26'h08, 32'h0, 32'h3, 1'b0);
		add_test("sckdiv_readback", op_apb_rd, sz_word, 26'h0C, 32'h0, 32'h3, 1'b0);
		add_test("ce2_slow_read", op_mem_rd, sz_word, 26'h2000400, 32'h0, w[5], 1'b0);
		add_test("lat1_set", op_apb_wr, sz_word, 26'h04, 32'hC, 32'h0, 1'b0);
		add_test("lat1_readback", op_apb_rd, sz_word, 26'h04, 32'h0, 32'hC, 1'b0);
		add_test("ce1_half_read", op_mem_rd, sz_half, 26'h1000400, 32'h0, {16'd0, w[4][15:0]}, 1'b0);
		add_test("sckdiv_set2", op_apb_wr, sz_word, 26'h0C, 32'h2, 32'h0, 1'b0);
		add_test("ce1_write_div2", op_mem_wr, sz_word, 26'h1000800, w[6], 32'h0, 1'b0);
		add_test("ce1_read_div2", op_mem_rd, sz_word, 26'h1000800, 32'h0, w[6], 1'b0);
		add_test("busy_hold", op_busy, sz_word, 26'h0000400, 32'h0, w[3], 1'b0);
	endtask

	// behavioural quad-SPI memory, sees the pins one clock late
	initial begin : flash_model
		logic [1:0] chip;
		logic [7:0] byte_v;
		int j;
		for (int i = 0; i < 16384; i++) begin
			flash_mem[i] = fill_byte(i[13:0]);
		end
		sio_i = 4'h0;
		rise_n = 0;
		xfer_cnt = 0;
		prev_sck = 1'b1;
		in_xfer = 1'b0;
		is_wr = 1'b0;
		is_rd = 1'b0;
		last_cmd = 8'h00;
		forever begin
			@(posedge clk);
			chip = 2'd0;
			for (int c = 0; c < 3; c++) begin
				if (!pins.ce_n[c]) begin
					chip = c[1:0];
				end
			end
			if (pins.ce_n == 3'b111) begin
				rise_n = 0;
				in_xfer = 1'b0;
			end else begin
				if (!in_xfer) begin
					xfer_cnt++;
					is_wr = 1'b0;
					is_rd = 1'b0;
				end
				in_xfer = 1'b1;
				if (pins.sck && !prev_sck) begin
					if (rise_n < 8) begin
						cmd_sr = {cmd_sr[6:0], pins.sio_o[0]};
						if (rise_n == 7) begin
							last_cmd = cmd_sr;
							is_wr = (cmd_sr == shd_wrcmd);
							is_rd = (cmd_sr == shd_rdcmd);
						end
					end else if (rise_n < 14) begin
						adr_sr = {adr_sr[19:0], pins.sio_o};
					end else if (is_wr) begin
						j = rise_n - 14;
						if (j % 2 == 0) begin
							hi_nib = pins.sio_o;
						end else begin
							flash_mem[mem_key(chip, adr_sr + j / 2)] = {hi_nib, pins.sio_o};
						end
					end
					rise_n++;
				end else if (!pins.sck && prev_sck && is_rd && rise_n >= 14 + mdl_lat[chip]) begin
					// next nibble after the falling edge, high nibble first
					j = rise_n - 14 - mdl_lat[chip];
					if (j < 8) begin
						byte_v = flash_mem[mem_key(chip, adr_sr + j / 2)];
						sio_i <= (j % 2 == 0) ? byte_v[7:4] : byte_v[3:0];
					end
				end
			end
			prev_sck = pins.sck;
		end
	end

	initial begin
		test_t       t;
		logic [31:0] got;
		logic        err_got;
		logic        rdy_got;
		int          dones;
		logic        late;
		int          xfers_before;
		logic [7:0]  exp_cmd;
		int          k;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 32'h0;
		req = 1'b0;
		req_info = '0;
		for (int i = 0; i < 3; i++) begin
			mdl_lat[i] = 4'd7;
		end
		shd_div = 10'd1;
		shd_rdcmd = 8'hEB;
		shd_wrcmd = 8'h38;
		rng = 32'ha210_a7ad;
		build_table();
		cycle_limit = 2 * (cycle_budget + 16);
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_ok = 1'b1;
		assert (!busy && !done && pins.ce_n == 3'b111 && !pins.sio_en && pins.sck) else begin
			$display("reset_state: outputs are not idle after reset");
			test_ok = 1'b0;
		end
		if (test_ok) begin
			$display("PASS reset_state");
			pass_cnt++;
		end else begin
			$display("FAIL reset_state");
			fail_cnt++;
		end
		for (int idx = 0; idx < n_tests; idx++) begin
			t = tbl[idx];
			test_ok = 1'b1;
			case (t.op)
				op_apb_wr: begin
					apb_write(t.adr[7:0], t.data);
					case (t.adr[7:0])
						8'h00: mdl_lat[0] = t.data[3:0];
						8'h04: mdl_lat[1] = t.data[3:0];
						8'h08: mdl_lat[2] = t.data[3:0];
						8'h0C: shd_div = t.data[9:0];
						8'h10: shd_rdcmd = t.data[7:0];
						8'h14: shd_wrcmd = t.data[7:0];
						default: ;
					endcase
				end
				op_apb_rd: begin
					apb_read(t.adr[7:0], got, err_got, rdy_got);
					assert (got == t.exp) else report_mismatch(tname[idx], "prdata", t.exp, got);
					assert (err_got == t.err) else
						report_mismatch(tname[idx], "pslverr", {31'd0, t.err}, {31'd0, err_got});
					assert (rdy_got) else
						report_mismatch(tname[idx], "pready", 32'h1, {31'd0, rdy_got});
				end
				op_mem_chk: begin
					k = mem_key(t.adr[25:24], t.adr[23:0]);
					got = {flash_mem[k + 3], flash_mem[k + 2], flash_mem[k + 1], flash_mem[k]};
					assert (got == t.data) else
						report_mismatch(tname[idx], "stored bytes", t.data, got);
				end
				default: begin
					xfers_before = xfer_cnt;
					mem_xfer(t.op == op_mem_wr, t.size, t.adr, t.data,
						(t.op == op_busy) ? 12 : 1, got, dones, late);
					assert (!late) else begin
						$display("%s: the transfer did not finish in time", tname[idx]);
						test_ok = 1'b0;
					end
					assert (dones == 1) else begin
						$display("%s: saw %0d done pulses instead of one", tname[idx], dones);
						test_ok = 1'b0;
					end
					assert (xfer_cnt - xfers_before == 1) else begin
						$display("%s: the memory saw %0d transfers instead of one",
							tname[idx], xfer_cnt - xfers_before);
						test_ok = 1'b0;
					end
					exp_cmd = (t.op == op_mem_wr) ? shd_wrcmd : shd_rdcmd;
					assert (last_cmd == exp_cmd) else
						report_mismatch(tname[idx], "command", {24'd0, exp_cmd}, {24'd0, last_cmd});
					if (t.op != op_mem_wr) begin
						assert (got == t.exp) else report_mismatch(tname[idx], "rdata", t.exp, got);
					end
				end
			endcase
			if (test_ok) begin
				$display("PASS %s", tname[idx]);
				pass_cnt++;
			end else begin
				$display("FAIL %s", tname[idx]);
				fail_cnt++;
			end
		end
		$display("%0d tests run, %0d passed, %0d failed", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* compile.f */
hw/qspi_pkg.sv
hw/qspi_cfg_regs.sv
hw/qspi_sck_gen.sv
hw/qspi_seq.sv
hw/qspi_datapath.sv
hw/qspi_ctrl.sv
tests/qspi_chk.sv
tests/qspi_tb.sv
